/* design/dino_pkg.sv */
`default_nettype none

package dino_pkg;

	// Screen geometry, 320x240
	localparam int X_BITS = 9;
	localparam int Y_BITS = 8;

	typedef logic [X_BITS-1:0] xpos_t;
	typedef logic [Y_BITS-1:0] ypos_t;

	localparam int SCREEN_W = 320;
	localparam int DINO_X   = 52;  // Runner never moves in x
	localparam int GROUND_Y = 109;
	localparam int OBST_Y   = 109;

	// Runner hitbox sits inside a 32x32 image
	localparam int DINO_HB_X_OFS  = 6;
	localparam int DINO_HB_Y_OFS  = 2;
	localparam int DINO_HB_W      = 20;
	localparam int DINO_HB_H      = 30;
	localparam int DINO_HB_H_DUCK = 15;
	localparam int OBST_SIZE      = 16;

	// Physics in pixels per scroll step, negative is upward
	typedef logic signed [9:0] vel_t;
	localparam vel_t JUMP_FORCE = -10'sd10;
	localparam vel_t GRAVITY    = 10'sd1;

	localparam int RESPAWN_SPAN = 100;

	typedef logic [15:0] score_t;
	typedef logic [3:0] digit_t;
	typedef logic [6:0] seg7_t;         // Active low, g..a
	typedef seg7_t [5:0] hex_bank_t;    // [2:0] score, [5:3] high score

	typedef logic [7:0] byte_t;

	typedef struct packed {
		logic jump;
		logic duck;
	} cmd_t;

	typedef struct packed {
		ypos_t dino_y;
		xpos_t obstacle_x;
		logic  ducking;
	} status_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	typedef enum logic {RUNNING, AIRBORNE} air_state_t;

endpackage

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none

module uart_rx import dino_pkg::*; #(
	parameter int CLK_HZ = 50_000_000,
	parameter int BAUD   = 115_200
) (
	input  logic  Clock,
	input  logic  rst_n,
	input  logic  uart_in,
	output byte_t rx_byte,
	output logic  rx_valid
);

	localparam int DIV    = CLK_HZ / (BAUD * 16);
	localparam int TICK_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;       // 16 ticks per bit
	logic              line_meta;
	logic              line_sync;
	rx_state_t         state;
	logic [3:0]        os_cnt;
	logic [2:0]        bit_idx;
	byte_t             shift;
	logic              sample_bit;
	logic              byte_done;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			tick     <= 1'b0;
		end else if (tick_cnt == TICK_W'(DIV - 1)) begin
			tick_cnt <= '0;
			tick     <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			tick     <= 1'b0;
		end
	end

	// Line idles high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			line_meta <= 1'b1;
			line_sync <= 1'b1;
		end else begin
			line_meta <= uart_in;
			line_sync <= line_meta;
		end
	end

	assign sample_bit = tick && (state == RX_DATA) && (os_cnt == 4'd0);
	assign byte_done  = tick && (state == RX_STOP) && (os_cnt == 4'd0);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state    <= RX_IDLE;
			os_cnt   <= 4'd0;
			bit_idx  <= 3'd0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= byte_done;
			if (tick) begin
				case (state)
					RX_IDLE: if (!line_sync) begin
						state  <= RX_START;
						os_cnt <= 4'd7;  // Half a bit to the middle of start
					end
					RX_START: if (os_cnt != 4'd0) begin
						os_cnt <= os_cnt - 1'b1;
					end else if (!line_sync) begin
						state   <= RX_DATA;
						os_cnt  <= 4'd15;
						bit_idx <= 3'd0;
					end else begin
						state <= RX_IDLE;  // Glitch, not a start bit
					end
					RX_DATA: if (os_cnt != 4'd0) begin
						os_cnt <= os_cnt - 1'b1;
					end else begin
						os_cnt  <= 4'd15;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
					RX_STOP: if (os_cnt != 4'd0)
						os_cnt <= os_cnt - 1'b1;
					else
						state <= RX_IDLE;
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge Clock) begin
		if (sample_bit)
			shift <= {line_sync, shift[7:1]};
		if (byte_done)
			rx_byte <= shift;
	end

	a_valid_single: assert property (@(posedge Clock) disable iff (!rst_n)
		rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

/* design/player_input.sv */
`default_nettype none

module player_input import dino_pkg::*; #(
	parameter int DUCK_STEPS = 96
) (
	input  logic  Clock,
	input  logic  rst_n,
	input  logic  key_jump_n,
	input  logic  key_duck_n,
	input  byte_t rx_byte,
	input  logic  rx_valid,
	input  logic  step,
	input  logic  airborne,
	output cmd_t  cmd,
	output logic  ducking
);

	localparam int DUCK_W = $clog2(DUCK_STEPS + 1);

	logic [1:0]        key_meta;   // [1] jump, [0] duck
	logic [1:0]        key_sync;
	logic [1:0]        key_prev;
	logic [1:0]        key_fall;
	logic              byte_jump;
	logic              byte_duck;
	logic [DUCK_W-1:0] duck_left;

	// Keys are active low, released reads as 1
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			key_meta <= '1;
			key_sync <= '1;
			key_prev <= '1;
		end else begin
			key_meta <= {key_jump_n, key_duck_n};
			key_sync <= key_meta;
			key_prev <= key_sync;
		end
	end

	assign key_fall  = key_prev & ~key_sync;
	assign byte_jump = rx_valid && (rx_byte == byte_t'("J"));
	assign byte_duck = rx_valid && (rx_byte == byte_t'("D"));

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			cmd <= '0;
		end else begin
			cmd.jump <= key_fall[1] | byte_jump;
			cmd.duck <= key_fall[0] | byte_duck;
		end
	end

	// Duck time counts scroll steps
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			ducking   <= 1'b0;
			duck_left <= '0;
		end else if (cmd.duck && !airborne && !ducking) begin
			ducking   <= 1'b1;
			duck_left <= DUCK_W'(DUCK_STEPS);
		end else if (ducking && step) begin
			if (duck_left == DUCK_W'(1))
				ducking <= 1'b0;
			duck_left <= duck_left - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/runner_physics.sv */
`default_nettype none

module runner_physics import dino_pkg::*; (
	input  logic  Clock,
	input  logic  rst_n,
	input  logic  step,
	input  cmd_t  cmd,
	input  logic  ducking,
	input  logic  game_over,
	input  logic  round_restart,
	output ypos_t dino_y,
	output logic  airborne
);

	localparam logic signed [Y_BITS+2:0] GROUND_EXT = (Y_BITS + 3)'(GROUND_Y);

	air_state_t                state;
	vel_t                      vel;
	logic signed [Y_BITS+2:0] next_y;  // Room for the sign and overshoot

	assign next_y   = signed'({3'b000, dino_y}) + (Y_BITS + 3)'(vel);
	assign airborne = (state == AIRBORNE);

	always_ff @(posedge Clock) begin
		if (!rst_n || round_restart) begin
			state  <= RUNNING;
			vel    <= '0;
			dino_y <= ypos_t'(GROUND_Y);
		end else if (!game_over) begin
			if (cmd.jump && !ducking && state == RUNNING) begin
				vel   <= JUMP_FORCE;  // Takes effect on the next step
				state <= AIRBORNE;
			end else if (step && state == AIRBORNE) begin
				// Predict the landing so y never sinks below ground
				if (next_y >= GROUND_EXT) begin
					dino_y <= ypos_t'(GROUND_Y);
					vel    <= '0;
					state  <= RUNNING;
				end else begin
					dino_y <= next_y[Y_BITS-1:0];
					vel    <= vel + GRAVITY;
				end
			end
		end
	end

	// On the ground exactly while running, never below it
	a_ground_bound: assert property (@(posedge Clock) disable iff (!rst_n)
		(dino_y <= ypos_t'(GROUND_Y)) && (airborne || dino_y == ypos_t'(GROUND_Y)));

endmodule

`default_nettype wire

/* design/obstacle_track.sv */
`default_nettype none

module obstacle_track import dino_pkg::*; #(
	parameter int STEP_DIV = 524_288
) (
	input  logic  Clock,
	input  logic  rst_n,
	input  logic  game_over,
	input  logic  round_restart,
	input  logic  score_event,
	output logic  step,
	output xpos_t obstacle_x
);

	localparam int DIV_W = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic [15:0]      lfsr;
	xpos_t            offset;

	// Taps 16, 15, 13, 4
	always_ff @(posedge Clock) begin
		if (!rst_n)
			lfsr <= 16'hACE1;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
	end

	always_ff @(posedge Clock)
		offset <= xpos_t'(lfsr % RESPAWN_SPAN);

	always_ff @(posedge Clock) begin
		if (!rst_n || round_restart) begin
			div_cnt    <= '0;
			step       <= 1'b0;
			obstacle_x <= xpos_t'(SCREEN_W);  // Just off screen
		end else if (game_over) begin
			step <= 1'b0;  // Track frozen
		end else begin
			step <= (div_cnt == DIV_W'(STEP_DIV - 1));
			if (div_cnt == DIV_W'(STEP_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;

			if (score_event)
				obstacle_x <= xpos_t'(SCREEN_W - OBST_SIZE) + offset;
			else if (step) begin
				if (obstacle_x <= xpos_t'(1))
					obstacle_x <= xpos_t'(SCREEN_W - OBST_SIZE);
				else
					obstacle_x <= obstacle_x - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/game_referee.sv */
`default_nettype none

module game_referee import dino_pkg::*; (
	input  logic    Clock,
	input  logic    rst_n,
	input  status_t status,
	input  cmd_t    cmd,
	output logic    game_over,
	output logic    score_event,
	output logic    round_restart,
	output score_t  score,
	output score_t  high_score
);

	// Fixed edges, one bit wider than the coordinates
	localparam logic [X_BITS:0] DINO_L = (X_BITS + 1)'(DINO_X + DINO_HB_X_OFS);
	localparam logic [X_BITS:0] DINO_R = (X_BITS + 1)'(DINO_X + DINO_HB_X_OFS + DINO_HB_W);
	localparam logic [Y_BITS:0] OBST_T = (Y_BITS + 1)'(OBST_Y);
	localparam logic [Y_BITS:0] OBST_B = (Y_BITS + 1)'(OBST_Y + OBST_SIZE);

	logic [X_BITS:0] obst_l;
	logic [X_BITS:0] obst_r;
	logic [Y_BITS:0] dino_h;
	logic [Y_BITS:0] dino_t;
	logic [Y_BITS:0] dino_b;
	logic            x_hit;
	logic            y_hit;
	logic            overlap;
	xpos_t           prev_x;
	logic            crossed;

	assign obst_l = {1'b0, status.obstacle_x};
	assign obst_r = obst_l + (X_BITS + 1)'(OBST_SIZE);

	// Ducking halves the runner height
	assign dino_h = status.ducking ? (Y_BITS + 1)'(DINO_HB_H_DUCK) : (Y_BITS + 1)'(DINO_HB_H);
	assign dino_t = {1'b0, status.dino_y} + (Y_BITS + 1)'(DINO_HB_Y_OFS);
	assign dino_b = dino_t + dino_h;

	assign x_hit   = (DINO_R >= obst_l) && (DINO_L <= obst_r);
	assign y_hit   = (dino_b >= OBST_T) && (dino_t <= OBST_B);
	assign overlap = x_hit && y_hit;

	assign crossed = (prev_x > xpos_t'(DINO_X)) && (status.obstacle_x <= xpos_t'(DINO_X));

	assign score_event   = crossed && !overlap && !game_over;
	assign round_restart = game_over && cmd.jump;  // New round, high score kept

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			game_over  <= 1'b0;
			score      <= '0;
			high_score <= '0;
			prev_x     <= xpos_t'(SCREEN_W);
		end else begin
			prev_x <= status.obstacle_x;
			if (round_restart) begin
				game_over <= 1'b0;
				score     <= '0;
			end else if (!game_over && overlap) begin
				game_over <= 1'b1;
				if (score > high_score)
					high_score <= score;
			end else if (score_event) begin
				score <= score + 1'b1;
			end
		end
	end

	a_no_score_at_loss: assert property (@(posedge Clock) disable iff (!rst_n)
		!($rose(score_event) && $rose(game_over)));

endmodule

`default_nettype wire

/* design/score_display.sv */
`default_nettype none

module score_display import dino_pkg::*; (
	input  score_t    score,
	input  score_t    high_score,
	output hex_bank_t hex
);

	function automatic digit_t digit_of(input score_t value, input int unsigned weight);
		return digit_t'((value / weight) % 10);
	endfunction

	// Standard active-low table, blank for anything above 9
	function automatic seg7_t seg_of(input digit_t d);
		case (d)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	always_comb begin
		hex[0] = seg_of(digit_of(score, 1));
		hex[1] = seg_of(digit_of(score, 10));
		hex[2] = seg_of(digit_of(score, 100));
		hex[3] = seg_of(digit_of(high_score, 1));
		hex[4] = seg_of(digit_of(high_score, 10));
		hex[5] = seg_of(digit_of(high_score, 100));
	end

endmodule

`default_nettype wire

/* design/dino_game_top.sv */
`default_nettype none

module dino_game_top import dino_pkg::*; #(
	parameter int CLK_HZ     = 50_000_000,
	parameter int BAUD       = 115_200,
	parameter int STEP_DIV   = 524_288,
	parameter int DUCK_STEPS = 96
) (
	input  logic      Clock,
	input  logic      rst_n,
	input  logic      uart_in,
	input  logic      key_jump_n,
	input  logic      key_duck_n,
	output status_t   status,
	output logic      game_over,
	output score_t    score,
	output score_t    high_score,
	output hex_bank_t hex
);

	byte_t rx_byte;
	logic  rx_valid;
	cmd_t  cmd;
	logic  ducking;
	logic  step;
	logic  airborne;
	logic  duck_block;
	ypos_t dino_y;
	xpos_t obstacle_x;
	logic  score_event;
	logic  round_restart;

	assign duck_block = airborne | game_over;  // No new duck while frozen
	assign status     = '{dino_y: dino_y, obstacle_x: obstacle_x, ducking: ducking};

	uart_rx #(.CLK_HZ(CLK_HZ), .BAUD(BAUD)) u_uart_rx (
		.Clock(Clock), .rst_n(rst_n), .uart_in(uart_in),
		.rx_byte(rx_byte), .rx_valid(rx_valid)
	);

	player_input #(.DUCK_STEPS(DUCK_STEPS)) u_player_input (
		.Clock(Clock), .rst_n(rst_n), .key_jump_n(key_jump_n), .key_duck_n(key_duck_n),
		.rx_byte(rx_byte), .rx_valid(rx_valid), .step(step), .airborne(duck_block),
		.cmd(cmd), .ducking(ducking)
	);

	runner_physics u_runner_physics (
		.Clock(Clock), .rst_n(rst_n), .step(step), .cmd(cmd), .ducking(ducking),
		.game_over(game_over), .round_restart(round_restart),
		.dino_y(dino_y), .airborne(airborne)
	);

	obstacle_track #(.STEP_DIV(STEP_DIV)) u_obstacle_track (
		.Clock(Clock), .rst_n(rst_n), .game_over(game_over), .round_restart(round_restart),
		.score_event(score_event), .step(step), .obstacle_x(obstacle_x)
	);

	game_referee u_game_referee (
		.Clock(Clock), .rst_n(rst_n), .status(status), .cmd(cmd),
		.game_over(game_over), .score_event(score_event), .round_restart(round_restart),
		.score(score), .high_score(high_score)
	);

	score_display u_score_display (.score(score), .high_score(high_score), .hex(hex));

endmodule

`default_nettype wire

/* bench/tb_dino_game.sv */
`default_nettype none

module tb_dino_game import dino_pkg::*; ();

	localparam int CLK_HZ       = 16_000_000;
	localparam int BAUD         = 250_000;
	localparam int STEP_DIV     = 16;
	localparam int DUCK_STEPS   = 20;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int BIT_CLKS     = CLK_HZ / BAUD;
	localparam int N_BYTES      = 60;
	localparam int N_PRESSES    = 20;
	localparam int HOLD_CYCLES  = 8;
	localparam int MAX_GAP      = 16 + 63;
	localparam int MAX_ROUNDS   = 8;
	localparam int CMD_WINDOW   = BIT_CLKS + 2 * STEP_DIV;  // Command to visible response
	localparam int AIR_LIMIT    = 30 * STEP_DIV;
	localparam int WATCHDOG_CYCLES = N_BYTES * 12 * BIT_CLKS
		+ N_PRESSES * (HOLD_CYCLES + MAX_GAP) + MAX_ROUNDS * 200 * STEP_DIV;

	// Active-low g..a patterns for 0..9
	localparam seg7_t SEG_TABLE [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
		7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

	logic      Clock;
	logic      rst_n;
	logic      uart_in;
	logic      key_jump_n;
	logic      key_duck_n;
	status_t   status;
	logic      game_over;
	score_t    score;
	score_t    high_score;
	hex_bank_t hex;

	logic        jump_req;  // One cycle, marks a jump command sent
	logic        duck_req;
	int          jump_left;
	int          duck_left;
	logic        start_clean;
	logic        start_over;
	logic        saw_lift;
	logic        saw_fell;
	int          air_cycles;
	xpos_t       prev_obst_x;
	logic        overlap_now;
	logic        score_due;
	logic [31:0] lfsr_state = 32'hcb22_0dfa;

	dino_game_top #(
		.CLK_HZ(CLK_HZ), .BAUD(BAUD), .STEP_DIV(STEP_DIV), .DUCK_STEPS(DUCK_STEPS)
	) dut (
		.Clock(Clock), .rst_n(rst_n), .uart_in(uart_in),
		.key_jump_n(key_jump_n), .key_duck_n(key_duck_n),
		.status(status), .game_over(game_over), .score(score),
		.high_score(high_score), .hex(hex)
	);

	initial begin
		Clock = 1'b0;
		forever #(CLK_PERIOD / 2) Clock = ~Clock;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int take_bits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
		return value;
	endfunction

	function automatic logic boxes_touch(input status_t s);
		int dino_l;
		int dino_r;
		int dino_t;
		int dino_b;
		int obst_l;
		int obst_r;
		dino_l = DINO_X + DINO_HB_X_OFS;
		dino_r = dino_l + DINO_HB_W;
		dino_t = int'(s.dino_y) + DINO_HB_Y_OFS;
		dino_b = dino_t + (s.ducking ? DINO_HB_H_DUCK : DINO_HB_H);  // Half height ducked
		obst_l = int'(s.obstacle_x);
		obst_r = obst_l + OBST_SIZE;
		return (dino_r >= obst_l) && (dino_l <= obst_r)
			&& (dino_b >= OBST_Y) && (dino_t <= OBST_Y + OBST_SIZE);
	endfunction

	function automatic hex_bank_t expected_hex(input score_t s, input score_t h);
		hex_bank_t bank;
		bank[0] = SEG_TABLE[s % 10];
		bank[1] = SEG_TABLE[(s / 10) % 10];
		bank[2] = SEG_TABLE[(s / 100) % 10];
		bank[3] = SEG_TABLE[h % 10];
		bank[4] = SEG_TABLE[(h / 10) % 10];
		bank[5] = SEG_TABLE[(h / 100) % 10];
		return bank;
	endfunction

	task automatic report_error(input string what);
		$display("ERROR at time %0t: %s", $time, what);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first failing check");
	endtask

	// 8N1 frame, LSB first
	task automatic send_byte(input byte_t value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge Clock);
			uart_in  <= frame[i];
			jump_req <= (i == 9) && (value == byte_t'("J"));
			duck_req <= (i == 9) && (value == byte_t'("D"));
			@(posedge Clock);
			jump_req <= 1'b0;
			duck_req <= 1'b0;
			repeat (BIT_CLKS - 2) @(posedge Clock);
		end
	endtask

	task automatic press_key(input logic is_jump);
		@(posedge Clock);
		if (is_jump)
			key_jump_n <= 1'b0;
		else
			key_duck_n <= 1'b0;
		jump_req <= is_jump;
		duck_req <= !is_jump;
		@(posedge Clock);
		jump_req <= 1'b0;
		duck_req <= 1'b0;
		repeat (HOLD_CYCLES - 1) @(posedge Clock);
		key_jump_n <= 1'b1;
		key_duck_n <= 1'b1;
	endtask

	initial begin
		int    kind;
		byte_t value;
		rst_n      = 1'b0;
		uart_in    = 1'b1;  // Line idles high
		key_jump_n = 1'b1;
		key_duck_n = 1'b1;
		jump_req   = 1'b0;
		duck_req   = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clock);
		rst_n <= 1'b1;
		repeat (4) @(posedge Clock);
		for (int i = 0; i < N_BYTES + N_PRESSES; i++) begin
			if (i % 4 == 3) begin
				press_key(take_bits(1) == 1);
			end else begin
				kind = take_bits(2);
				if (kind < 2)
					value = byte_t'("J");
				else if (kind == 2)
					value = byte_t'("D");
				else begin
					value = byte_t'(take_bits(8));  // Noise byte
					if (value == byte_t'("J") || value == byte_t'("D"))
						value = 8'h55;
				end
				send_byte(value);
			end
			repeat (16 + take_bits(6)) @(posedge Clock);
		end
		repeat (4 * STEP_DIV) @(posedge Clock);
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	assign overlap_now = boxes_touch(status);
	assign score_due   = (prev_obst_x > xpos_t'(DINO_X)) && (status.obstacle_x <= xpos_t'(DINO_X))
		&& !overlap_now && !game_over;

	// Response windows after each command
	always @(posedge Clock) begin
		prev_obst_x <= status.obstacle_x;
		if (!rst_n) begin
			jump_left  <= 0;
			duck_left  <= 0;
			air_cycles <= 0;
		end else begin
			if (jump_req) begin
				jump_left   <= CMD_WINDOW;
				start_clean <= (status.dino_y == ypos_t'(GROUND_Y)) && !game_over
					&& !status.ducking;
				start_over  <= game_over;
				saw_lift    <= 1'b0;
				saw_fell    <= 1'b0;
			end else if (jump_left != 0) begin
				jump_left <= jump_left - 1;
				if (game_over || status.ducking)
					start_clean <= 1'b0;
				if (status.dino_y < ypos_t'(GROUND_Y))
					saw_lift <= 1'b1;
				if (!game_over)
					saw_fell <= 1'b1;
			end
			if (duck_req)
				duck_left <= CMD_WINDOW;
			else if (duck_left != 0)
				duck_left <= duck_left - 1;
			if (status.dino_y == ypos_t'(GROUND_Y))
				air_cycles <= 0;
			else if (!game_over)
				air_cycles <= air_cycles + 1;  // Frozen jumps do not count
		end
	end

	a_never_below_ground: assert property (@(posedge Clock) disable iff (!rst_n)
		status.dino_y <= ypos_t'(GROUND_Y))
		else report_error("dino_y above GROUND_Y in value");
	a_lift_on_command: assert property (@(posedge Clock) disable iff (!rst_n)
		($past(status.dino_y) == ypos_t'(GROUND_Y) && status.dino_y != ypos_t'(GROUND_Y))
		|-> (jump_left != 0 && status.dino_y == ypos_t'(GROUND_Y + JUMP_FORCE)))
		else report_error("runner left the ground without a jump or to a wrong height");
	a_jump_answered: assert property (@(posedge Clock) disable iff (!rst_n)
		(jump_left == 1 && start_clean) |-> saw_lift)
		else report_error("jump command did not lift the runner within 2 steps");
	a_air_time_bounded: assert property (@(posedge Clock) disable iff (!rst_n)
		air_cycles < AIR_LIMIT)
		else report_error("runner did not return to GROUND_Y");
	a_duck_on_command: assert property (@(posedge Clock) disable iff (!rst_n)
		$rose(status.ducking) |-> duck_left != 0)
		else report_error("ducking rose without a duck command");
	a_game_over_on_overlap: assert property (@(posedge Clock) disable iff (!rst_n)
		(!game_over && overlap_now) |=> game_over)
		else report_error("game_over missing one cycle after overlap");
	a_game_over_cause: assert property (@(posedge Clock) disable iff (!rst_n)
		$rose(game_over) |-> $past(overlap_now))
		else report_error("game_over rose without overlap");
	a_frozen: assert property (@(posedge Clock) disable iff (!rst_n)
		($past(game_over) && game_over) |-> ($stable(status.dino_y)
		&& $stable(status.obstacle_x) && !$rose(status.ducking)))
		else report_error("status moved during game over");
	a_score_step: assert property (@(posedge Clock) disable iff (!rst_n)
		score_due |=> score == score_t'($past(score) + 1'b1))
		else report_error("score did not count a passed obstacle");
	a_score_hold: assert property (@(posedge Clock) disable iff (!rst_n)
		(score != $past(score)) |-> ((score == '0 && $past(game_over))
		|| ($past(score_due) && score == score_t'($past(score) + 1'b1))))
		else report_error("score changed without a score event or restart");
	a_high_on_loss: assert property (@(posedge Clock) disable iff (!rst_n)
		$rose(game_over) |-> high_score == (($past(score) > $past(high_score))
		? $past(score) : $past(high_score)))
		else report_error("high_score is not the maximum at game over");
	a_high_hold: assert property (@(posedge Clock) disable iff (!rst_n)
		!$rose(game_over) |-> $stable(high_score))
		else report_error("high_score changed outside game over");
	a_restart: assert property (@(posedge Clock) disable iff (!rst_n)
		$fell(game_over) |-> score == '0)
		else report_error("score not cleared on restart");
	a_restart_answered: assert property (@(posedge Clock) disable iff (!rst_n)
		(jump_left == 1 && start_over) |-> saw_fell)
		else report_error("jump during game over did not restart the round");
	a_hex: assert property (@(posedge Clock) disable iff (!rst_n)
		hex == expected_hex(score, high_score))
		else report_error("seven-segment digits do not match score and high_score");

endmodule

`default_nettype wire

/* files.f */
design/dino_pkg.sv
design/uart_rx.sv
design/player_input.sv
design/runner_physics.sv
design/obstacle_track.sv
design/game_referee.sv
design/score_display.sv
design/dino_game_top.sv
bench/tb_dino_game.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dino_game
FILELIST = files.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exit code is ignored, the log decides
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
